// ==== logic/input_pkg.sv ====
//====================
// Shared widths and constants for the player input section
// USB and DB15 control bit positions, dial limits, speed codes
//====================

package input_pkg;

	// Control word and dial sizes
	localparam int JOY_W = 16;
	localparam int DIAL_W = 4;
	localparam logic [DIAL_W-1:0] DIAL_MAX = 4'd11;   // Top position, also reset value
	localparam int DIV_W_DEFAULT = 23;                 // ~6.4 Hz step at 53.6 MHz

	// Rotary speed select
	localparam logic [1:0] SPEED_NORMAL = 2'd0;
	localparam logic [1:0] SPEED_SLOW = 2'd1;
	localparam logic [1:0] SPEED_FAST = 2'd2;
	localparam logic [1:0] SPEED_VFAST = 2'd3;

	// Download bus
	localparam logic [7:0] DIP_INDEX = 8'd254;
	localparam logic [7:0] GAME_INDEX = 8'd1;
	localparam int DIP_COUNT = 8;

	//====================
	// USB joystick word, active high
	//====================
	localparam int USB_RIGHT = 0;
	localparam int USB_LEFT = 1;
	localparam int USB_DOWN = 2;
	localparam int USB_UP = 3;
	localparam int USB_SHOT = 4;
	localparam int USB_MISSILE = 5;
	localparam int USB_START = 6;
	localparam int USB_COIN = 7;
	localparam int USB_ROT_L = 8;
	localparam int USB_ROT_R = 9;
	localparam int USB_SERVICE = 10;
	localparam int USB_PAUSE = 11;

	//====================
	// DB15 word, active low, NeoGeo layout
	//====================
	localparam int DB_RIGHT = 0;
	localparam int DB_LEFT = 1;
	localparam int DB_DOWN = 2;
	localparam int DB_UP = 3;
	localparam int DB_A = 4;
	localparam int DB_B = 5;
	localparam int DB_C = 6;
	localparam int DB_D = 7;
	localparam int DB_START = 10;
	localparam int DB_SELECT = 11;

endpackage

// ==== logic/stick_mapper.sv ====
//====================
// Control source select and polarity for one player
// USB word or DB15 pad, NeoGeo or LS-30 button layout
//====================
`timescale 1ns/100ps

module stick_mapper (
	input  logic [input_pkg::JOY_W-1:0] joy_usb,   // Active high
	input  logic [input_pkg::JOY_W-1:0] joy_db15,  // Active low
	input  logic                        db15_sel,
	input  logic                        ls30_sel,
	output logic                        up_n,
	output logic                        down_n,
	output logic                        left_n,
	output logic                        right_n,
	output logic                        shot_n,
	output logic                        missile_n,
	output logic                        start_n,
	output logic                        coin_n,
	output logic                        service_n,
	output logic                        rot_left,
	output logic                        rot_right,
	output logic                        pause
);

	logic use_db;

	assign use_db = db15_sel | ls30_sel;   // Any pad on the DB15 port

	always_comb begin
		if (use_db) begin
			// DB15 already active low, directions pass straight
			up_n      = joy_db15[input_pkg::DB_UP];
			down_n    = joy_db15[input_pkg::DB_DOWN];
			left_n    = joy_db15[input_pkg::DB_LEFT];
			right_n   = joy_db15[input_pkg::DB_RIGHT];
			start_n   = joy_db15[input_pkg::DB_START];
			coin_n    = joy_db15[input_pkg::DB_SELECT];
			// NeoGeo B,C vs LS-30 A,B
			shot_n    = db15_sel ? joy_db15[input_pkg::DB_B] : joy_db15[input_pkg::DB_A];
			missile_n = db15_sel ? joy_db15[input_pkg::DB_C] : joy_db15[input_pkg::DB_B];
			// Select+B gives service
			service_n = joy_db15[input_pkg::DB_B] | joy_db15[input_pkg::DB_SELECT];
			pause     = joy_db15[input_pkg::DB_A] & joy_db15[input_pkg::DB_SELECT];
			rot_left  = ~joy_db15[input_pkg::DB_A];
			rot_right = ~joy_db15[input_pkg::DB_D];
		end else begin
			up_n      = ~joy_usb[input_pkg::USB_UP];
			down_n    = ~joy_usb[input_pkg::USB_DOWN];
			left_n    = ~joy_usb[input_pkg::USB_LEFT];
			right_n   = ~joy_usb[input_pkg::USB_RIGHT];
			start_n   = ~joy_usb[input_pkg::USB_START];
			coin_n    = ~joy_usb[input_pkg::USB_COIN];
			shot_n    = ~joy_usb[input_pkg::USB_SHOT];
			missile_n = ~joy_usb[input_pkg::USB_MISSILE];
			service_n = ~joy_usb[input_pkg::USB_SERVICE];
			pause     = joy_usb[input_pkg::USB_PAUSE];    // Rotate and pause stay high true
			rot_left  = joy_usb[input_pkg::USB_ROT_L];
			rot_right = joy_usb[input_pkg::USB_ROT_R];
		end
	end

endmodule

// ==== logic/rotary_tick.sv ====
//====================
// Free-running divider for the rotary dials
// One-cycle step enable at the selected speed
//====================
`timescale 1ns/100ps

module rotary_tick #(
	parameter int DIV_W = input_pkg::DIV_W_DEFAULT   // Needs at least 3 bits
) (
	input  logic       clk_53p6,
	input  logic       reset,
	input  logic [1:0] rot_speed,
	output logic       step
);

	logic [DIV_W-1:0] div_cnt;

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;   // Wraps freely
		end
	end

	// Fewer low bits checked gives a faster step
	always_comb begin
		step = 1'b0;
		case (rot_speed)
			input_pkg::SPEED_NORMAL: step = (div_cnt == '0);
			input_pkg::SPEED_SLOW:   step = (div_cnt == '0);   // Same period as normal
			input_pkg::SPEED_FAST:   step = (div_cnt[DIV_W-2:0] == '0);
			input_pkg::SPEED_VFAST:  step = (div_cnt[DIV_W-3:0] == '0);
		endcase
	end

endmodule

// ==== logic/rotary_dial.sv ====
//====================
// 12-position rotary dial for one player
// Wraps at both ends, left wins over right
//====================
`timescale 1ns/100ps

module rotary_dial (
	input  logic                         clk_53p6,
	input  logic                         reset,
	input  logic                         step,       // From rotary_tick
	input  logic                         rot_left,
	input  logic                         rot_right,
	output logic [input_pkg::DIAL_W-1:0] position
);

	logic [input_pkg::DIAL_W-1:0] pos_inc;
	logic [input_pkg::DIAL_W-1:0] pos_dec;

	// Next positions with wrap
	always_comb begin
		if (position == input_pkg::DIAL_MAX) begin
			pos_inc = '0;
		end else begin
			pos_inc = position + 1'b1;
		end

		if (position == '0) begin
			pos_dec = input_pkg::DIAL_MAX;   // 0 back to 11
		end else begin
			pos_dec = position - 1'b1;
		end
	end

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			position <= input_pkg::DIAL_MAX;
		end else if (step) begin
			if (rot_left) begin
				position <= pos_inc;   // Left has priority
			end else if (rot_right) begin
				position <= pos_dec;
			end
		end
	end

endmodule

// ==== logic/dip_bank.sv ====
//====================
// DIP switch bytes and game number
// Captured from the ROM download bus
//====================
`timescale 1ns/100ps

module dip_bank (
	input  logic        clk_53p6,
	input  logic        reset,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic [7:0]  dsw1,
	output logic [7:0]  dsw2,
	output logic [7:0]  game
);

	localparam int SEL_W = $clog2(input_pkg::DIP_COUNT);

	logic [7:0] sw [input_pkg::DIP_COUNT];
	logic       dip_hit;
	logic       game_hit;

	// Address decode for the two download targets
	assign dip_hit = ioctl_wr && (ioctl_index == input_pkg::DIP_INDEX) &&
		(ioctl_addr < 25'(input_pkg::DIP_COUNT));
	assign game_hit = ioctl_wr && (ioctl_index == input_pkg::GAME_INDEX) &&
		(ioctl_addr == '0);

	always_ff @(posedge clk_53p6) begin
		if (reset) begin
			for (int i = 0; i < input_pkg::DIP_COUNT; i++) begin
				sw[i] <= '0;
			end
			game <= '0;
		end else begin
			if (dip_hit) sw[ioctl_addr[SEL_W-1:0]] <= ioctl_dout;
			if (game_hit) game <= ioctl_dout;   // Multigame select
		end
	end

	// Only the first two banks go to the core
	assign dsw1 = sw[0];
	assign dsw2 = sw[1];

endmodule

// ==== logic/player_inputs.sv ====
//====================
// Player input section top level
// Two stick mappers, rotary dials, DIP capture, player word packing
//====================
`timescale 1ns/100ps

module player_inputs #(
	parameter int DIV_W = input_pkg::DIV_W_DEFAULT
) (
	input  logic                        clk_53p6,
	input  logic                        reset,
	input  logic [input_pkg::JOY_W-1:0] joy_usb_1,
	input  logic [input_pkg::JOY_W-1:0] joy_usb_2,
	input  logic [input_pkg::JOY_W-1:0] joy_db15_1,
	input  logic [input_pkg::JOY_W-1:0] joy_db15_2,
	input  logic [1:0]                  db15_sel,    // Bit 0 player 1
	input  logic [1:0]                  ls30_sel,
	input  logic [1:0]                  rot_speed,
	input  logic                        ioctl_wr,
	input  logic [7:0]                  ioctl_index,
	input  logic [24:0]                 ioctl_addr,
	input  logic [7:0]                  ioctl_dout,
	output logic [15:0]                 player1,
	output logic [15:0]                 player2,
	output logic [7:0]                  dsw1,
	output logic [7:0]                  dsw2,
	output logic [7:0]                  game,
	output logic                        pause_req
);

	// Per-player control bits, index 0 is player 1
	logic [1:0] up_n, down_n, left_n, right_n;
	logic [1:0] shot_n, missile_n, start_n, coin_n, service_n;
	logic [1:0] rot_left, rot_right, pause;
	logic       step;
	logic [input_pkg::DIAL_W-1:0] pos1;
	logic [input_pkg::DIAL_W-1:0] pos2;

	//====================
	// Control mapping
	//====================
	stick_mapper u_map1 (
		.joy_usb(joy_usb_1), .joy_db15(joy_db15_1),
		.db15_sel(db15_sel[0]), .ls30_sel(ls30_sel[0]),
		.up_n(up_n[0]), .down_n(down_n[0]), .left_n(left_n[0]), .right_n(right_n[0]),
		.shot_n(shot_n[0]), .missile_n(missile_n[0]),
		.start_n(start_n[0]), .coin_n(coin_n[0]), .service_n(service_n[0]),
		.rot_left(rot_left[0]), .rot_right(rot_right[0]), .pause(pause[0])
	);

	stick_mapper u_map2 (
		.joy_usb(joy_usb_2), .joy_db15(joy_db15_2),
		.db15_sel(db15_sel[1]), .ls30_sel(ls30_sel[1]),
		.up_n(up_n[1]), .down_n(down_n[1]), .left_n(left_n[1]), .right_n(right_n[1]),
		.shot_n(shot_n[1]), .missile_n(missile_n[1]),
		.start_n(start_n[1]), .coin_n(coin_n[1]), .service_n(service_n[1]),
		.rot_left(rot_left[1]), .rot_right(rot_right[1]), .pause(pause[1])
	);

	//====================
	// Rotary dials
	//====================
	rotary_tick #(.DIV_W(DIV_W)) u_tick (
		.clk_53p6(clk_53p6), .reset(reset), .rot_speed(rot_speed), .step(step)
	);

	// Both dials share one step
	rotary_dial u_dial1 (
		.clk_53p6(clk_53p6), .reset(reset), .step(step),
		.rot_left(rot_left[0]), .rot_right(rot_right[0]), .position(pos1)
	);

	rotary_dial u_dial2 (
		.clk_53p6(clk_53p6), .reset(reset), .step(step),
		.rot_left(rot_left[1]), .rot_right(rot_right[1]), .position(pos2)
	);

	dip_bank u_dip (
		.clk_53p6(clk_53p6), .reset(reset), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.dsw1(dsw1), .dsw2(dsw2), .game(game)
	);

	// Port word, controls active low, dial in 7:4
	assign player1 = {2'b11, up_n[0], down_n[0], right_n[0], left_n[0], service_n[0],
		1'b1, pos1, missile_n[0], shot_n[0], start_n[0], coin_n[0]};
	assign player2 = {2'b11, up_n[1], down_n[1], right_n[1], left_n[1], service_n[1],
		1'b1, pos2, missile_n[1], shot_n[1], start_n[1], coin_n[1]};

	assign pause_req = pause[0] | pause[1];   // Either player

endmodule

// ==== tb/tb_model.svh ====
//====================
// Reference functions for the player input testbench
// Player word, pause, rotate, dial and step rules
//====================
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected 16-bit port word for one player
function automatic logic [15:0] packed_word(input logic [15:0] usb, input logic [15:0] db,
	input logic dsel, input logic lsel, input logic [3:0] pos);
	logic up, down, right, left, serv, miss, shot, start, coin;
	if (dsel | lsel) begin
		up    = db[input_pkg::DB_UP];      // Pad bits already active low
		down  = db[input_pkg::DB_DOWN];
		right = db[input_pkg::DB_RIGHT];
		left  = db[input_pkg::DB_LEFT];
		start = db[input_pkg::DB_START];
		coin  = db[input_pkg::DB_SELECT];
		shot  = dsel ? db[input_pkg::DB_B] : db[input_pkg::DB_A];
		miss  = dsel ? db[input_pkg::DB_C] : db[input_pkg::DB_B];
		// Service only with B and Select both pressed
		serv  = ~(~db[input_pkg::DB_B] & ~db[input_pkg::DB_SELECT]);
	end else begin
		up    = ~usb[input_pkg::USB_UP];
		down  = ~usb[input_pkg::USB_DOWN];
		right = ~usb[input_pkg::USB_RIGHT];
		left  = ~usb[input_pkg::USB_LEFT];
		start = ~usb[input_pkg::USB_START];
		coin  = ~usb[input_pkg::USB_COIN];
		shot  = ~usb[input_pkg::USB_SHOT];
		miss  = ~usb[input_pkg::USB_MISSILE];
		serv  = ~usb[input_pkg::USB_SERVICE];
	end
	return {2'b11, up, down, right, left, serv, 1'b1, pos, miss, shot, start, coin};
endfunction

function automatic logic pause_of(input logic [15:0] usb, input logic [15:0] db,
	input logic use_db);
	return use_db ? (db[input_pkg::DB_A] & db[input_pkg::DB_SELECT]) : usb[input_pkg::USB_PAUSE];
endfunction

// Left in bit 1, right in bit 0
function automatic logic [1:0] rotate_of(input logic [15:0] usb, input logic [15:0] db,
	input logic use_db);
	if (use_db) return {~db[input_pkg::DB_A], ~db[input_pkg::DB_D]};
	return {usb[input_pkg::USB_ROT_L], usb[input_pkg::USB_ROT_R]};
endfunction

function automatic logic [3:0] next_position(input logic [3:0] pos, input logic [1:0] rot);
	if (rot[1]) return (pos == 4'd11) ? 4'd0 : pos + 4'd1;   // Left first
	if (rot[0]) return (pos == 4'd0) ? 4'd11 : pos - 4'd1;
	return pos;
endfunction

function automatic logic step_due(input logic [DIV_W-1:0] div, input logic [1:0] speed);
	case (speed)
		2'd0, 2'd1: return div == '0;           // Full period
		2'd2:       return div[DIV_W-2:0] == '0;
		default:    return div[DIV_W-3:0] == '0;
	endcase
endfunction

`endif

// ==== tb/tb_player_inputs.sv ====
//====================
// Testbench for the player input section
// Clock, reset, LFSR stimulus, model counters, compare process
//====================
`timescale 1ns/100ps

module tb_player_inputs;

	localparam int DIV_W = 6;   // Short divider for simulation

	logic        clk_53p6 = 1'b0;
	logic        reset;
	logic [15:0] joy_usb_1, joy_usb_2, joy_db15_1, joy_db15_2;
	logic [1:0]  db15_sel, ls30_sel, rot_speed;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index, ioctl_dout;
	logic [24:0] ioctl_addr;
	logic [15:0] player1, player2;
	logic [7:0]  dsw1, dsw2, game;
	logic        pause_req;

	// Model state
	logic [DIV_W-1:0] div_m;
	logic [3:0]  dial_m1, dial_m2;
	logic [7:0]  dsw1_m, dsw2_m, game_m;
	int          steps_m = 0;
	logic [31:0] lfsr = 32'h58066e70;
	int          checks = 0;
	int          word_errs = 0;
	int          bank_errs = 0;
	int          direct_errs = 0;
	logic        timed_out = 1'b0;
	logic        checking = 1'b0;

	`include "tb_model.svh"

	always #10 clk_53p6 = ~clk_53p6;   // 20 ns

	player_inputs #(.DIV_W(DIV_W)) UUT (
		.clk_53p6(clk_53p6), .reset(reset), .joy_usb_1(joy_usb_1), .joy_usb_2(joy_usb_2),
		.joy_db15_1(joy_db15_1), .joy_db15_2(joy_db15_2), .db15_sel(db15_sel),
		.ls30_sel(ls30_sel), .rot_speed(rot_speed), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.player1(player1), .player2(player2), .dsw1(dsw1), .dsw2(dsw2), .game(game),
		.pause_req(pause_req)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);   // One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic drive_random();
		logic [31:0] v;
		rand_bits(32, v);
		joy_usb_1 <= v[15:0];
		joy_usb_2 <= v[31:16];
		rand_bits(32, v);
		joy_db15_1 <= v[15:0];
		joy_db15_2 <= v[31:16];
	endtask

	task automatic download(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_53p6);
		ioctl_wr <= 1'b1;
		ioctl_index <= index;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_53p6);
		ioctl_wr <= 1'b0;   // Single-cycle strobe
	endtask

	task automatic wait_steps(input int n);
		int start;
		int cycles;
		start = steps_m;
		cycles = 0;
		while (steps_m - start < n && cycles < n * 80) begin
			@(posedge clk_53p6);
			cycles++;
		end
		if (steps_m - start < n) begin
			$display("Timeout: the dial tick did not step %0d times", n);
			timed_out = 1'b1;
		end
	endtask

	// Player 1 rotates from USB and player 2 from the DB15 pad
	task automatic hold_rotation(input logic [15:0] usb, input logic [15:0] db_low, input int n);
		@(posedge clk_53p6);
		joy_usb_1 <= usb;
		joy_db15_2 <= ~db_low;
		wait_steps(n);
	endtask

	//====================
	// Model counters
	//====================
	always @(posedge clk_53p6) begin
		if (reset) begin
			div_m <= '0;
			dial_m1 <= 4'd11;
			dial_m2 <= 4'd11;
			dsw1_m <= '0;
			dsw2_m <= '0;
			game_m <= '0;
		end else begin
			div_m <= div_m + DIV_W'(1);
			if (step_due(div_m, rot_speed)) begin
				dial_m1 <= next_position(dial_m1,
					rotate_of(joy_usb_1, joy_db15_1, db15_sel[0] | ls30_sel[0]));
				dial_m2 <= next_position(dial_m2,
					rotate_of(joy_usb_2, joy_db15_2, db15_sel[1] | ls30_sel[1]));
				steps_m <= steps_m + 1;
			end
			if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr == 25'd0) dsw1_m <= ioctl_dout;
			if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr == 25'd1) dsw2_m <= ioctl_dout;
			if (ioctl_wr && ioctl_index == 8'd1 && ioctl_addr == 25'd0) game_m <= ioctl_dout;
		end
	end

	//====================
	// Compare on the falling edge
	//====================
	always @(negedge clk_53p6) begin : compare
		logic [15:0] exp1;
		logic [15:0] exp2;
		logic        exp_p;
		exp1 = packed_word(joy_usb_1, joy_db15_1, db15_sel[0], ls30_sel[0], dial_m1);
		exp2 = packed_word(joy_usb_2, joy_db15_2, db15_sel[1], ls30_sel[1], dial_m2);
		exp_p = pause_of(joy_usb_1, joy_db15_1, db15_sel[0] | ls30_sel[0]) |
			pause_of(joy_usb_2, joy_db15_2, db15_sel[1] | ls30_sel[1]);
		if (checking) begin
			checks++;
			if (player1 !== exp1 || player2 !== exp2 || pause_req !== exp_p) begin
				word_errs++;
				$display("Fail %0t: words %h %h pause %b, expected %h %h pause %b",
					$time, player1, player2, pause_req, exp1, exp2, exp_p);
			end
			if ({dsw1, dsw2, game} !== {dsw1_m, dsw2_m, game_m}) begin
				bank_errs++;
				$display("Fail %0t: dsw %h %h game %h, expected %h %h %h",
					$time, dsw1, dsw2, game, dsw1_m, dsw2_m, game_m);
			end
		end
	end

	task automatic run_tests();
		logic [31:0] v;
		logic [7:0]  byte0;
		logic [7:0]  byte1;
		repeat (5) @(posedge clk_53p6);
		reset <= 1'b0;
		checking = 1'b1;
		@(negedge clk_53p6);
		// Idle state with the dial at 11
		if (player1 !== 16'hFFBF || player2 !== 16'hFFBF || pause_req !== 1'b0) begin
			direct_errs++;
			$display("Fail %0t: idle words %h %h pause %b", $time, player1, player2, pause_req);
		end
		if ({dsw1, dsw2, game} !== 24'h0) begin
			direct_errs++;
			$display("Fail %0t: download bytes not cleared by reset", $time);
		end
		repeat (300) begin   // USB mode
			@(posedge clk_53p6);
			drive_random();
		end
		for (int k = 0; k < 4; k++) begin   // Each pad type on each player
			@(posedge clk_53p6);
			db15_sel <= (k == 0) ? 2'b01 : (k == 1) ? 2'b10 : 2'b00;
			ls30_sel <= (k == 2) ? 2'b01 : (k == 3) ? 2'b10 : 2'b00;
			repeat (150) begin
				@(posedge clk_53p6);
				drive_random();
			end
		end
		@(posedge clk_53p6);
		db15_sel <= 2'b10;
		ls30_sel <= 2'b00;
		joy_usb_2 <= '0;
		joy_db15_1 <= 16'hFFFF;
		for (int s = 0; s < 4; s++) begin
			@(posedge clk_53p6);
			rot_speed <= 2'(s);
			hold_rotation(16'h0100, 16'h0010, 14);   // Left through 11 to 0
			hold_rotation(16'h0200, 16'h0080, 14);   // Right through 0 to 11
			hold_rotation(16'h0300, 16'h0090, 3);    // Left wins when both held
			if (timed_out) return;
		end
		byte0 = '0;
		byte1 = '0;
		for (int a = 0; a < 10; a++) begin
			rand_bits(8, v);
			if (a == 0) byte0 = v[7:0];
			if (a == 1) byte1 = v[7:0];
			download(8'd254, 25'(a), v[7:0]);
		end
		download(8'd0, 25'd0, 8'hAA);   // Other indices are ignored
		download(8'd3, 25'd1, 8'h55);
		download(8'd1, 25'd0, 8'h5A);
		download(8'd1, 25'd3, 8'hC3);
		@(posedge clk_53p6);
		ioctl_index <= 8'd1;   // Game address held without the strobe
		ioctl_addr <= '0;
		ioctl_dout <= 8'h77;
		@(posedge clk_53p6);
		@(negedge clk_53p6);
		if (dsw1 !== byte0 || dsw2 !== byte1 || game !== 8'h5A) begin
			direct_errs++;
			$display("Fail %0t: dsw %h %h game %h, expected %h %h 5a",
				$time, dsw1, dsw2, game, byte0, byte1);
		end
		repeat (4) @(posedge clk_53p6);
	endtask

	initial begin
		reset <= 1'b1;
		joy_usb_1 <= '0;
		joy_usb_2 <= '0;
		joy_db15_1 <= 16'hFFFF;   // Pad released
		joy_db15_2 <= 16'hFFFF;
		db15_sel <= 2'b00;
		ls30_sel <= 2'b00;
		rot_speed <= 2'b00;
		ioctl_wr <= 1'b0;
		ioctl_index <= '0;
		ioctl_addr <= '0;
		ioctl_dout <= '0;
		run_tests();
		$display("Checks %0d, errors word %0d download %0d direct %0d, timeout %0d",
			checks, word_errs, bank_errs, direct_errs, timed_out);
		if (!timed_out && word_errs == 0 && bank_errs == 0 && direct_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+tb
logic/input_pkg.sv
logic/stick_mapper.sv
logic/rotary_tick.sv
logic/rotary_dial.sv
logic/dip_bank.sv
logic/player_inputs.sv
tb/tb_player_inputs.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the player input testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_player_inputs \
	-o sim_player_inputs > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_player_inputs > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qF "** PASS **" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
